/* hdl/sha256_pkg.sv */
// --------------------
// SHA-256 engine types, constants and round functions
// --------------------
`default_nettype none

package sha256_pkg;

	typedef logic [31:0]  word_t;
	typedef logic [7:0]   byte_t;
	typedef logic [511:0] block_t;
	typedef logic [5:0]   round_idx_t;

	localparam int ROUNDS       = 64;
	localparam int DIGEST_WORDS = 8;
	localparam int SCHED_WORDS  = 16;

	// One-cycle phase strobes
	typedef struct packed {
		logic h_valid;
		logic msg_valid;
		logic pad;
		logic init;
		logic round;
		logic accum;
		logic clear;
	} ctrl_t;

	typedef enum logic [2:0] {
		IDLE,
		LOAD_H,
		LOAD_MSG,
		PAD,
		ROUND,
		ACCUM,
		WRITE
	} state_t;

	function automatic word_t rotr(input word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic word_t ssig0(input word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t ssig1(input word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	function automatic word_t bsig0(input word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t bsig1(input word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic word_t ch(input word_t x, input word_t y, input word_t z);
		return (x & y) ^ (~x & z);
	endfunction

	function automatic word_t maj(input word_t x, input word_t y, input word_t z);
		return (x & y) ^ (x & z) ^ (y & z);
	endfunction

endpackage

`default_nettype wire

/* hdl/step_counter.sv */
// --------------------
// Shared address and round index counter
// --------------------
`timescale 1ns/1ps
`default_nettype none

module step_counter import sha256_pkg::*; (
	input  wire        clk,
	input  wire        rst,
	input  wire        clr,
	input  wire        inc,
	output round_idx_t count
);

	// Clear wins over increment
	always_ff @(posedge clk)
	begin
		if (rst || clr)
			count <= '0;
		else if (inc)
			count <= count + 1'b1;
	end

endmodule

`default_nettype wire

/* hdl/sha256_control.sv */
// --------------------
// SHA-256 phase FSM
// Sequences memory reads, padding, rounds and digest writes
// --------------------
`timescale 1ns/1ps
`default_nettype none

module sha256_control import sha256_pkg::*; #(
	parameter int MAX_MSG_LEN = 55,
	localparam int LEN_W = $clog2(MAX_MSG_LEN + 1)
) (
	input  wire             clk,
	input  wire             rst,
	input  wire             go,
	input  wire [LEN_W-1:0] msg_length,
	input  wire round_idx_t count,
	output ctrl_t           ctrl,
	output logic            count_clr,
	output logic            count_inc,
	output logic            finish,
	output logic            msg_enable,
	output logic            kmem_enable,
	output logic            hmem_enable,
	output logic            dom_enable,
	output logic            dom_write
);

	state_t state;
	state_t state_nxt;
	logic [LEN_W-1:0] len_q;
	logic last;

	// Exit test and successor for each phase
	always_comb
	begin
		last = 1'b0;
		state_nxt = IDLE;
		case (state)
			LOAD_H:
			begin
				last = (count == round_idx_t'(DIGEST_WORDS - 1));
				state_nxt = (len_q == '0) ? PAD : LOAD_MSG;
			end
			LOAD_MSG:
			begin
				last = (count == round_idx_t'(len_q - 1'b1));
				state_nxt = PAD;
			end
			PAD:
			begin
				last = (count == round_idx_t'(1));
				state_nxt = ROUND;
			end
			ROUND:
			begin
				last = (count == round_idx_t'(ROUNDS - 1));
				state_nxt = ACCUM;
			end
			ACCUM:
			begin
				last = (count == round_idx_t'(1));
				state_nxt = WRITE;
			end
			WRITE:
			begin
				last = (count == round_idx_t'(DIGEST_WORDS - 1));
				state_nxt = IDLE;
			end
			default:
			begin
				last = go;
				state_nxt = LOAD_H;
			end
		endcase
		if (!last)
			state_nxt = state;
	end

	assign count_clr   = last;
	assign count_inc   = (state != IDLE);
	assign finish      = (state == IDLE);
	assign hmem_enable = (state == LOAD_H);
	assign msg_enable  = (state == LOAD_MSG);
	assign kmem_enable = (state == ROUND);
	assign dom_enable  = (state == WRITE);
	assign dom_write   = (state == WRITE);

	// Strobes trail the read enables by the memory latency
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			len_q <= '0;
			ctrl  <= '0;
		end
		else
		begin
			state <= state_nxt;
			if ((state == IDLE) && go)
				len_q <= msg_length;
			ctrl.clear     <= (state == IDLE) && go;
			ctrl.h_valid   <= hmem_enable;
			ctrl.msg_valid <= msg_enable;
			ctrl.pad       <= (state == PAD) && (count == '0);
			ctrl.round     <= kmem_enable;
			ctrl.init      <= kmem_enable && (count == '0);
			ctrl.accum     <= (state == ACCUM) && (count == '0);
		end
	end

endmodule

`default_nettype wire

/* hdl/message_loader.sv */
// --------------------
// Message block builder
// Packs bytes big-endian and appends the SHA-256 padding
// --------------------
`timescale 1ns/1ps
`default_nettype none

module message_loader import sha256_pkg::*; #(
	parameter int MAX_MSG_LEN = 55,
	localparam int LEN_W = $clog2(MAX_MSG_LEN + 1)
) (
	input  wire             clk,
	input  wire             rst,
	input  wire ctrl_t      ctrl,
	input  wire [LEN_W-1:0] msg_length,
	input  wire round_idx_t slot,
	input  wire byte_t      msg_data,
	output block_t          block
);

	logic [LEN_W-1:0] len_q;
	round_idx_t slot_q;
	logic [8:0] byte_lsb;
	logic [8:0] mark_lsb;

	always_ff @(posedge clk)
	begin
		if (rst)
			len_q <= '0;
		else if (ctrl.clear)
			len_q <= msg_length;
	end

	// Byte n sits at bits 511-8n down to 504-8n
	assign byte_lsb = 9'd504 - {slot_q, 3'b000};
	assign mark_lsb = 9'd504 - {round_idx_t'(len_q), 3'b000};

	always_ff @(posedge clk)
	begin
		// Address of the byte now returning
		slot_q <= slot;
		if (ctrl.clear)
			block <= '0;
		else if (ctrl.msg_valid)
			block[byte_lsb +: 8] <= msg_data;
		else if (ctrl.pad)
		begin
			block[mark_lsb +: 8] <= 8'h80;
			block[63:0] <= 64'(len_q) << 3;
		end
	end

endmodule

`default_nettype wire

/* hdl/schedule_unit.sv */
// --------------------
// Message schedule window
// Yields W[t] for each round from a 16-word shift window
// --------------------
`timescale 1ns/1ps
`default_nettype none

module schedule_unit import sha256_pkg::*; (
	input  wire        clk,
	input  wire        rst,
	input  wire ctrl_t ctrl,
	input  wire block_t block,
	output word_t      w
);

	// Index 15 is the oldest word, W[t-16]
	word_t [SCHED_WORDS-1:0] win_q;
	word_t w_new;
	logic load_q;

	always_ff @(posedge clk)
	begin
		if (rst)
			load_q <= 1'b0;
		else
			load_q <= ctrl.pad;
	end

	// W[t-2], W[t-7], W[t-15], W[t-16]
	assign w_new = ssig1(win_q[1]) + win_q[6] + ssig0(win_q[14]) + win_q[15];

	always_ff @(posedge clk)
	begin
		if (load_q)
			win_q <= block;
		else if (ctrl.round)
			win_q <= {win_q[SCHED_WORDS-2:0], w_new};
	end

	assign w = win_q[SCHED_WORDS-1];

endmodule

`default_nettype wire

/* hdl/compression_core.sv */
// --------------------
// SHA-256 compression rounds and hash word store
// --------------------
`timescale 1ns/1ps
`default_nettype none

module compression_core import sha256_pkg::*; (
	input  wire             clk,
	input  wire             rst,
	input  wire ctrl_t      ctrl,
	input  wire word_t      hmem_data,
	input  wire word_t      k,
	input  wire word_t      w,
	input  wire round_idx_t slot,
	output word_t           dom_data
);

	// Index 0 is a (or H0), index 7 is h (or H7)
	word_t [DIGEST_WORDS-1:0] h_q;
	word_t [DIGEST_WORDS-1:0] v_q;
	word_t [DIGEST_WORDS-1:0] src;
	word_t [DIGEST_WORDS-1:0] v_nxt;
	word_t t1;
	word_t t2;

	// --------------------
	// Round datapath
	// --------------------
	always_comb
	begin
		// First round starts straight from the hash words
		src = ctrl.init ? h_q : v_q;
		t1 = src[7] + bsig1(src[4]) + ch(src[4], src[5], src[6]) + k + w;
		t2 = bsig0(src[0]) + maj(src[0], src[1], src[2]);
		v_nxt = {src[6:4], src[3] + t1, src[2:0], t1 + t2};
	end

	always_ff @(posedge clk)
	begin
		if (ctrl.round)
			v_q <= v_nxt;
	end

	// --------------------
	// Hash words
	// --------------------
	always_ff @(posedge clk)
	begin
		if (rst)
			h_q <= '0;
		else if (ctrl.h_valid)
			// Words arrive in address order and shift down
			h_q <= {hmem_data, h_q[DIGEST_WORDS-1:1]};
		else if (ctrl.accum)
		begin
			for (int i = 0; i < DIGEST_WORDS; i++)
				h_q[i] <= h_q[i] + v_q[i];
		end
	end

	assign dom_data = h_q[slot[2:0]];

endmodule

`default_nettype wire

/* hdl/sha256_top.sv */
// --------------------
// Single-block SHA-256 engine top level
// --------------------
`timescale 1ns/1ps
`default_nettype none

module sha256_top import sha256_pkg::*; #(
	parameter int MAX_MSG_LEN = 55,
	localparam int LEN_W = $clog2(MAX_MSG_LEN + 1),
	localparam int ADDR_W = (MAX_MSG_LEN > 1) ? $clog2(MAX_MSG_LEN) : 1
) (
	input  wire              clk,
	input  wire              rst,
	input  wire              go,
	input  wire [LEN_W-1:0]  msg_length,
	input  wire byte_t       msg_data,
	input  wire word_t       kmem_data,
	input  wire word_t       hmem_data,
	output logic             finish,
	output logic             msg_enable,
	output logic [ADDR_W-1:0] msg_address,
	output logic             kmem_enable,
	output round_idx_t       kmem_address,
	output logic             hmem_enable,
	output logic [2:0]       hmem_address,
	output logic             dom_enable,
	output logic             dom_write,
	output logic [2:0]       dom_address,
	output word_t            dom_data
);

	ctrl_t ctrl;
	logic count_clr;
	logic count_inc;
	round_idx_t count;
	block_t block;
	word_t w;

	// One counter addresses every memory in turn
	assign msg_address  = count[ADDR_W-1:0];
	assign kmem_address = count;
	assign hmem_address = count[2:0];
	assign dom_address  = count[2:0];

	sha256_control #(
		.MAX_MSG_LEN(MAX_MSG_LEN)
	) u_control (
		.clk         (clk),
		.rst         (rst),
		.go          (go),
		.msg_length  (msg_length),
		.count       (count),
		.ctrl        (ctrl),
		.count_clr   (count_clr),
		.count_inc   (count_inc),
		.finish      (finish),
		.msg_enable  (msg_enable),
		.kmem_enable (kmem_enable),
		.hmem_enable (hmem_enable),
		.dom_enable  (dom_enable),
		.dom_write   (dom_write)
	);

	step_counter u_counter (
		.clk   (clk),
		.rst   (rst),
		.clr   (count_clr),
		.inc   (count_inc),
		.count (count)
	);

	message_loader #(
		.MAX_MSG_LEN(MAX_MSG_LEN)
	) u_loader (
		.clk        (clk),
		.rst        (rst),
		.ctrl       (ctrl),
		.msg_length (msg_length),
		.slot       (count),
		.msg_data   (msg_data),
		.block      (block)
	);

	schedule_unit u_schedule (
		.clk   (clk),
		.rst   (rst),
		.ctrl  (ctrl),
		.block (block),
		.w     (w)
	);

	compression_core u_core (
		.clk       (clk),
		.rst       (rst),
		.ctrl      (ctrl),
		.hmem_data (hmem_data),
		.k         (kmem_data),
		.w         (w),
		.slot      (count),
		.dom_data  (dom_data)
	);

endmodule

`default_nettype wire

/* test/sha256_assert.sv */
// --------------------
// Memory strobe assertions for the SHA-256 engine
// --------------------
`timescale 1ns/1ps
`default_nettype none

module sha256_assert (
	input wire clk,
	input wire rst,
	input wire finish,
	input wire msg_enable,
	input wire dom_enable,
	input wire dom_write
);

	write_has_enable: assert property (@(posedge clk) disable iff (rst)
		dom_write |-> dom_enable)
		else $error("dom_write high without dom_enable");

	// Idle engine touches no memory
	idle_no_output: assert property (@(posedge clk) disable iff (rst)
		finish |-> !dom_enable)
		else $error("dom_enable high while finish is high");

	idle_no_message: assert property (@(posedge clk) disable iff (rst)
		finish |-> !msg_enable)
		else $error("msg_enable high while finish is high");

endmodule

bind sha256_top sha256_assert u_assert (
	.clk        (clk),
	.rst        (rst),
	.finish     (finish),
	.msg_enable (msg_enable),
	.dom_enable (dom_enable),
	.dom_write  (dom_write)
);

`default_nettype wire

/* test/tb_sha256.sv */
// --------------------
// SHA-256 engine testbench
// Memory models, vector table and a reference digest model
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_sha256 import sha256_pkg::*; ();

	localparam int MAX_MSG_LEN = 55;
	localparam int LEN_W = $clog2(MAX_MSG_LEN + 1);
	localparam int ADDR_W = $clog2(MAX_MSG_LEN);
	localparam int NUM_VEC = 5;
	localparam int RUN_TIMEOUT = 400;
	localparam int LOG_DEPTH = 64;
	localparam logic [255:0] ABC_DIGEST =
		256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad;

	logic clk = 1'b0;
	logic rst;
	logic go;
	logic [LEN_W-1:0] msg_length;
	byte_t msg_data = '0;
	word_t kmem_data = '0;
	word_t hmem_data = '0;
	logic finish;
	logic msg_enable;
	logic [ADDR_W-1:0] msg_address;
	logic kmem_enable;
	round_idx_t kmem_address;
	logic hmem_enable;
	logic [2:0] hmem_address;
	logic dom_enable;
	logic dom_write;
	logic [2:0] dom_address;
	word_t dom_data;

	byte_t msg_mem [64];
	word_t k_mem [ROUNDS];
	word_t h_mem [DIGEST_WORDS] = '{32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};
	word_t out_mem [DIGEST_WORDS];
	logic [2:0] write_addr [LOG_DEPTH];
	int write_count = 0;

	// Vector table with kind 0 for text and kind 1 for random bytes
	int vec_kind [NUM_VEC];
	string vec_text [NUM_VEC];
	int vec_len [NUM_VEC];
	logic [255:0] vec_pub [NUM_VEC];
	bit vec_has_pub [NUM_VEC];
	bit vec_extra_go [NUM_VEC];

	integer seed;
	int value_errors;
	int other_errors;
	bit timed_out;

	always #4 clk = ~clk;

	sha256_top #(
		.MAX_MSG_LEN(MAX_MSG_LEN)
	) dut (
		.clk          (clk),
		.rst          (rst),
		.go           (go),
		.msg_length   (msg_length),
		.msg_data     (msg_data),
		.kmem_data    (kmem_data),
		.hmem_data    (hmem_data),
		.finish       (finish),
		.msg_enable   (msg_enable),
		.msg_address  (msg_address),
		.kmem_enable  (kmem_enable),
		.kmem_address (kmem_address),
		.hmem_enable  (hmem_enable),
		.hmem_address (hmem_address),
		.dom_enable   (dom_enable),
		.dom_write    (dom_write),
		.dom_address  (dom_address),
		.dom_data     (dom_data)
	);

	// --------------------
	// Memory models
	// --------------------
	always @(posedge clk)
	begin
		if (msg_enable)
			msg_data <= msg_mem[msg_address];
		if (kmem_enable)
			kmem_data <= k_mem[kmem_address];
		if (hmem_enable)
			hmem_data <= h_mem[hmem_address];
	end

	// Output memory with a log of write addresses
	always @(posedge clk)
	begin
		if (dom_enable && dom_write)
		begin
			out_mem[dom_address] <= dom_data;
			if (write_count < LOG_DEPTH)
				write_addr[write_count] <= dom_address;
			write_count <= write_count + 1;
		end
	end

	// --------------------
	// Reference model
	// --------------------
	function automatic word_t rot_right(input word_t x, input int n);
		logic [63:0] twice;
		twice = {x, x} >> n;
		return twice[31:0];
	endfunction

	function automatic word_t small_sigma(input word_t x, input int r1, input int r2,
		input int s);
		return rot_right(x, r1) ^ rot_right(x, r2) ^ (x >> s);
	endfunction

	function automatic word_t big_sigma(input word_t x, input int r1, input int r2,
		input int r3);
		return rot_right(x, r1) ^ rot_right(x, r2) ^ rot_right(x, r3);
	endfunction

	// Single-block digest of msg_mem[0 .. len-1]
	task automatic reference_digest(input int len, output logic [255:0] digest);
		byte_t blk [64];
		word_t sched [64];
		word_t v [8];
		word_t t1;
		word_t t2;
		logic [63:0] bit_len;
		for (int i = 0; i < 64; i++)
			blk[i] = (i < len) ? msg_mem[i] : 8'h00;
		blk[len] = 8'h80;
		bit_len = 64'(len) * 64'd8;
		for (int i = 0; i < 8; i++)
			blk[56 + i] = bit_len[63 - 8 * i -: 8];
		for (int t = 0; t < 16; t++)
			sched[t] = {blk[4 * t], blk[4 * t + 1], blk[4 * t + 2], blk[4 * t + 3]};
		for (int t = 16; t < 64; t++)
			sched[t] = small_sigma(sched[t - 2], 17, 19, 10) + sched[t - 7]
				+ small_sigma(sched[t - 15], 7, 18, 3) + sched[t - 16];
		for (int i = 0; i < 8; i++)
			v[i] = h_mem[i];
		for (int t = 0; t < 64; t++)
		begin
			t1 = v[7] + big_sigma(v[4], 6, 11, 25) + ((v[4] & v[5]) ^ (~v[4] & v[6]))
				+ k_mem[t] + sched[t];
			t2 = big_sigma(v[0], 2, 13, 22) + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
			for (int i = 7; i > 0; i--)
				v[i] = v[i - 1];
			v[4] = v[4] + t1;
			v[0] = t1 + t2;
		end
		for (int i = 0; i < 8; i++)
			digest[255 - 32 * i -: 32] = h_mem[i] + v[i];
	endtask

	// --------------------
	// Stimulus and checks
	// --------------------
	task automatic set_vector(input int idx, input int kind, input string text, input int len,
		input logic [255:0] pub, input bit has_pub, input bit extra_go);
		vec_kind[idx] = kind;
		vec_text[idx] = text;
		vec_len[idx] = len;
		vec_pub[idx] = pub;
		vec_has_pub[idx] = has_pub;
		vec_extra_go[idx] = extra_go;
	endtask

	task automatic run_vector(input int idx);
		logic [255:0] expected;
		logic [255:0] got;
		string text;
		int base;
		int cycles;
		int writes;
		text = vec_text[idx];
		// Unused bytes hold a pattern the padding must hide
		for (int i = 0; i < 64; i++)
			msg_mem[i] = 8'hc0 ^ 8'(i);
		for (int i = 0; i < vec_len[idx]; i++)
		begin
			if (vec_kind[idx] == 1)
				msg_mem[i] = 8'($random(seed));
			else
				msg_mem[i] = byte_t'(text[i]);
		end
		reference_digest(vec_len[idx], expected);
		if (vec_has_pub[idx] && expected != vec_pub[idx])
		begin
			$display("[ERROR] reference digest got %h expected %h", expected, vec_pub[idx]);
			value_errors++;
		end
		base = write_count;
		@(posedge clk);
		#1;
		msg_length = LEN_W'(vec_len[idx]);
		go = 1'b1;
		@(posedge clk);
		#1;
		go = 1'b0;
		if (finish)
		begin
			$display("Vector %0d: finish did not fall after go", idx);
			other_errors++;
		end
		if (vec_extra_go[idx])
		begin
			repeat (6) @(posedge clk);
			#1;
			// A restart here would hash the empty message
			msg_length = '0;
			go = 1'b1;
			@(posedge clk);
			#1;
			go = 1'b0;
		end
		cycles = 0;
		while (!finish && cycles < RUN_TIMEOUT)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!finish)
		begin
			$display("Vector %0d: finish did not rise within %0d cycles", idx, RUN_TIMEOUT);
			other_errors++;
			timed_out = 1'b1;
			return;
		end
		// All writes must be done by the time finish rises
		writes = write_count - base;
		if (writes != DIGEST_WORDS)
		begin
			$display("[ERROR] write count at finish got %h expected %h", writes, DIGEST_WORDS);
			value_errors++;
		end
		for (int k = 0; k < DIGEST_WORDS && k < writes; k++)
		begin
			if (write_addr[base + k] != 3'(k))
			begin
				$display("[ERROR] dom_address write %0d got %h expected %h",
					k, write_addr[base + k], 3'(k));
				value_errors++;
			end
		end
		for (int i = 0; i < DIGEST_WORDS; i++)
		begin
			got[255 - 32 * i -: 32] = out_mem[i];
			if (out_mem[i] != expected[255 - 32 * i -: 32])
			begin
				$display("[ERROR] vector %0d dom_data word %0d got %h expected %h",
					idx, i, out_mem[i], expected[255 - 32 * i -: 32]);
				value_errors++;
			end
		end
		if (vec_has_pub[idx] && got != vec_pub[idx])
		begin
			$display("[ERROR] vector %0d digest got %h expected %h", idx, got, vec_pub[idx]);
			value_errors++;
		end
		// No late run from a stray go
		repeat (4) @(posedge clk);
		#1;
		if (!finish || write_count - base != DIGEST_WORDS)
		begin
			$display("[ERROR] vector %0d finish %h writes got %h expected %h",
				idx, finish, write_count - base, DIGEST_WORDS);
			value_errors++;
		end
	endtask

	initial
	begin
		rst = 1'b1;
		go = 1'b0;
		msg_length = '0;
		seed = 52113;
		value_errors = 0;
		other_errors = 0;
		timed_out = 1'b0;
		$readmemh("test/k_const.hex", k_mem);
		if (k_mem[0] != 32'h428a2f98 || k_mem[63] != 32'hc67178f2)
		begin
			$display("The K memory file did not load the round constants");
			other_errors++;
		end
		set_vector(0, 0, "", 0, '0, 1'b0, 1'b0);
		set_vector(1, 0, "abc", 3, ABC_DIGEST, 1'b1, 1'b0);
		set_vector(2, 1, "", 55, '0, 1'b0, 1'b0);
		set_vector(3, 0, "single block message", 20, '0, 1'b0, 1'b0);
		set_vector(4, 0, "abc", 3, ABC_DIGEST, 1'b1, 1'b1);
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		if (finish != 1'b1)
		begin
			$display("[ERROR] finish after reset got %h expected %h", finish, 1'b1);
			value_errors++;
		end
		if ({msg_enable, kmem_enable, hmem_enable, dom_enable, dom_write} != 5'h00)
		begin
			$display("[ERROR] enables after reset got %h expected %h",
				{msg_enable, kmem_enable, hmem_enable, dom_enable, dom_write}, 5'h00);
			value_errors++;
		end
		for (int i = 0; i < NUM_VEC && !timed_out; i++)
			run_vector(i);
		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* test/k_const.hex */
// One SHA-256 round constant K[t] per line, t from 0 to 63
428a2f98
71374491
b5c0fbcf
e9b5dba5
3956c25b
59f111f1
923f82a4
ab1c5ed5
d807aa98
12835b01
243185be
550c7dc3
72be5d74
80deb1fe
9bdc06a7
c19bf174
e49b69c1
efbe4786
0fc19dc6
240ca1cc
2de92c6f
4a7484aa
5cb0a9dc
76f988da
983e5152
a831c66d
b00327c8
bf597fc7
c6e00bf3
d5a79147
06ca6351
14292967
27b70a85
2e1b2138
4d2c6dfc
53380d13
650a7354
766a0abb
81c2c92e
92722c85
a2bfe8a1
a81a664b
c24b8b70
c76c51a3
d192e819
d6990624
f40e3585
106aa070
19a4c116
1e376c08
2748774c
34b0bcb5
391c0cb3
4ed8aa4a
5b9cca4f
682e6ff3
748f82ee
78a5636f
84c87814
8cc70208
90befffa
a4506ceb
bef9a3f7
c67178f2

/* verilog.f */
hdl/sha256_pkg.sv
hdl/step_counter.sv
hdl/sha256_control.sv
hdl/message_loader.sv
hdl/schedule_unit.sv
hdl/compression_core.sv
hdl/sha256_top.sv
test/sha256_assert.sv
test/tb_sha256.sv

/* run.sh */
#!/bin/sh
# Build the SHA-256 testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_sha256 -f verilog.f \
	-Mdir obj_dir > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_sha256 > sim.log 2>&1
cat sim.log
grep -q "^SIMULATION PASSED$" sim.log && exit 0 || { echo "Test run failed"; exit 1; }
